// File: project.f
design/l2_mem_pkg.sv
design/rst_stretch.sv
design/line_sequencer.sv
design/ram_beat_model.sv
design/l2_mem_top.sv
dv/l2_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 memory bridge testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

top=l2_mem_tb
mdir=obj_dir
exe=l2_mem_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" \
    --Mdir "$mdir" \
    -o "$exe" \
    -f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$("./$mdir/$exe" 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test OK" <<< "$sim_output"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: dv/l2_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l2_mem_tb;

    localparam int clk_half       = 20;
    localparam int reset_cycles   = 16;
    localparam int stretch_cycles = 32;
    localparam int idle_gap       = 4;
    localparam int n_entries      = 16;
    localparam int line_timeout   = l2_mem_pkg::beats_per_line * 8 * 2;

    // Table length times eight beats of eight cycles, plus reset and stretch
    localparam int watchdog_cycles = n_entries * l2_mem_pkg::beats_per_line * 8
                                     + reset_cycles + stretch_cycles + 4;

    localparam logic [1:0] op_wr   = 2'b01;
    localparam logic [1:0] op_rd   = 2'b10;
    localparam logic [1:0] op_both = 2'b11;

    typedef struct packed {
        logic [1:0]                       op;
        logic [l2_mem_pkg::tag_w-1:0]     tag;
        logic [l2_mem_pkg::index_w-1:0]   index;
        logic [7:0]                       seed;
    } req_entry_t;

    logic                             clk_cpu;
    logic                             rst_n;
    logic                             read_req;
    logic                             write_req;
    logic [l2_mem_pkg::tag_w-1:0]     tag;
    logic [l2_mem_pkg::tag_w-1:0]     write_tag;
    logic [l2_mem_pkg::index_w-1:0]   index;
    logic [l2_mem_pkg::line_w-1:0]    write_data;
    logic [l2_mem_pkg::line_w-1:0]    read_data;
    logic                             line_ready;

    req_entry_t                       req_table [n_entries];
    logic [31:0]                      lfsr_state;

    // Expected memory contents, keyed by tag bits 6..0 and the index
    logic [l2_mem_pkg::line_w-1:0]    ref_mem [logic [14:0]];

    // Deep enough that every key of the reference model has its own words
    l2_mem_top #(
        .MEM_WORDS  (1 << 18),
        .MIN_LAT    (2),
        .RST_CYCLES (stretch_cycles)
    ) dut (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .read_req   (read_req),
        .write_req  (write_req),
        .tag        (tag),
        .write_tag  (write_tag),
        .index      (index),
        .write_data (write_data),
        .read_data  (read_data),
        .line_ready (line_ready)
    );

    always #clk_half clk_cpu = ~clk_cpu;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string name,
                               input logic [l2_mem_pkg::line_w-1:0] actual,
                               input logic [l2_mem_pkg::line_w-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s mismatch: got %0h, expected %0h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // One LFSR step per data bit, then the seed byte over every byte lane
    task automatic make_line(input logic [7:0] seed,
                             output logic [l2_mem_pkg::line_w-1:0] line);
        for (int i = 0; i < l2_mem_pkg::line_w; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            line[i]    = lfsr_state[0];
        end
        line = line ^ {(l2_mem_pkg::line_w / 8){seed}};
    endtask

    task automatic load_table();
        // Never written so reads as zero
        req_table[0]  = '{op_rd,   18'h00000, 8'h00, 8'h00};
        req_table[1]  = '{op_wr,   18'h00005, 8'h10, 8'h11};
        req_table[2]  = '{op_rd,   18'h00005, 8'h10, 8'h00};
        // Neighbours in index and in tag bits 6 and 0
        req_table[3]  = '{op_wr,   18'h00005, 8'h11, 8'h22};
        req_table[4]  = '{op_wr,   18'h00045, 8'h10, 8'h33};
        req_table[5]  = '{op_wr,   18'h00004, 8'h10, 8'h44};
        req_table[6]  = '{op_rd,   18'h00005, 8'h10, 8'h00};
        req_table[7]  = '{op_rd,   18'h00005, 8'h11, 8'h00};
        req_table[8]  = '{op_rd,   18'h00045, 8'h10, 8'h00};
        req_table[9]  = '{op_rd,   18'h00004, 8'h10, 8'h00};
        // Read wins and the write data never lands
        req_table[10] = '{op_both, 18'h00005, 8'h10, 8'h55};
        req_table[11] = '{op_rd,   18'h00005, 8'h10, 8'h00};
        req_table[12] = '{op_both, 18'h0007f, 8'hff, 8'h66};
        req_table[13] = '{op_rd,   18'h0007f, 8'hff, 8'h00};
        req_table[14] = '{op_wr,   18'h3ff2a, 8'h80, 8'h77};
        req_table[15] = '{op_rd,   18'h3ff2a, 8'h80, 8'h00};
    endtask

    // Sampled on the falling edge away from the DUT's updates
    task automatic wait_line_ready();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_cpu);
            cycles++;
        end while (!line_ready && cycles < line_timeout);
        if (!line_ready) begin
            $display("Request timed out: no line_ready within %0d cycles", line_timeout);
            $display("Test FAILED");
            $fatal(1, "line_ready missing");
        end
    endtask

    task automatic apply_request(input req_entry_t e);
        logic [l2_mem_pkg::line_w-1:0] data;
        logic [l2_mem_pkg::line_w-1:0] expected;
        logic [14:0]                   key;
        data = '0;
        key  = {e.tag[6:0], e.index};
        if (e.op[0]) begin
            make_line(e.seed, data);
        end
        expected = ref_mem.exists(key) ? ref_mem[key] : '0;

        @(posedge clk_cpu);
        read_req   <= e.op[1];
        write_req  <= e.op[0];
        // The tag that the operation does not use points at another line
        tag        <= (e.op == op_wr) ? ~e.tag : e.tag;
        write_tag  <= (e.op == op_rd) ? ~e.tag : e.tag;
        index      <= e.index;
        write_data <= data;

        wait_line_ready();
        if (e.op[1]) begin
            check_value("read_data", read_data, expected);
        end else begin
            ref_mem[key] = data;
        end

        // Drop the request while line_ready is still high
        @(posedge clk_cpu);
        read_req  <= 1'b0;
        write_req <= 1'b0;

        // A single pulse per request
        repeat (idle_gap) begin
            @(negedge clk_cpu);
            check_value("line_ready", line_ready, '0);
        end
    endtask

    initial begin
        clk_cpu    = 1'b0;
        rst_n      = 1'b0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        tag        = '0;
        write_tag  = '0;
        index      = '0;
        write_data = '0;
        lfsr_state = 32'h406e;
        load_table();

        repeat (reset_cycles) begin
            @(negedge clk_cpu);
            check_value("line_ready", line_ready, '0);
        end
        @(posedge clk_cpu);
        rst_n <= 1'b1;

        // Internal reset still held so nothing may move
        repeat (stretch_cycles + 4) begin
            @(negedge clk_cpu);
            check_value("line_ready", line_ready, '0);
            check_value("read_data", read_data, '0);
        end

        for (int i = 0; i < n_entries; i++) begin
            apply_request(req_table[i]);
        end

        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_cpu);
        $display("Watchdog expired after %0d cycles, the DUT appears to hang", watchdog_cycles);
        $display("Test FAILED");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

// File: design/l2_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module l2_mem_top #(
    parameter int MEM_WORDS  = 4096,
    parameter int MIN_LAT    = 2,
    parameter int RST_CYCLES = 32
) (
    input  logic                           clk_cpu,
    input  logic                           rst_n,
    input  logic                           read_req,
    input  logic                           write_req,
    input  logic [l2_mem_pkg::tag_w-1:0]   tag,
    input  logic [l2_mem_pkg::tag_w-1:0]   write_tag,
    input  logic [l2_mem_pkg::index_w-1:0] index,
    input  logic [l2_mem_pkg::line_w-1:0]  write_data,
    output logic [l2_mem_pkg::line_w-1:0]  read_data,
    output logic                           line_ready
);

    logic                 rst_int_n;
    l2_mem_pkg::ram_req_t ram_req;
    l2_mem_pkg::ram_rsp_t ram_rsp;

    rst_stretch #(
        .RST_CYCLES (RST_CYCLES)
    ) u_rst_stretch (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .rst_int_n (rst_int_n)
    );

    // L2 side, one line in flight
    line_sequencer u_line_sequencer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_int_n),
        .read_req   (read_req),
        .write_req  (write_req),
        .tag        (tag),
        .write_tag  (write_tag),
        .index      (index),
        .write_data (write_data),
        .read_data  (read_data),
        .line_ready (line_ready),
        .ram_req    (ram_req),
        .ram_rsp    (ram_rsp)
    );

    // Stand-in for the DDR2 controller
    ram_beat_model #(
        .MEM_WORDS (MEM_WORDS),
        .MIN_LAT   (MIN_LAT)
    ) u_ram_beat_model (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_int_n),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

endmodule

`default_nettype wire

// File: design/ram_beat_model.sv
`timescale 1ns/10ps
`default_nettype none

module ram_beat_model #(
    parameter int MEM_WORDS = 4096,
    parameter int MIN_LAT   = 2
) (
    input  logic                 clk_cpu,
    input  logic                 rst_n,
    input  l2_mem_pkg::ram_req_t ram_req,
    output l2_mem_pkg::ram_rsp_t ram_rsp
);

    localparam int word_aw = $clog2(MEM_WORDS);
    localparam int cnt_w   = $clog2(MIN_LAT + 4);

    logic [l2_mem_pkg::beat_w-1:0] mem [MEM_WORDS];

    logic                          strobe;
    logic                          busy;
    logic                          done;
    logic                          complete_q;
    logic                          op_write;
    logic [word_aw-1:0]            word_q;
    logic [l2_mem_pkg::beat_w-1:0] wdata_q;
    logic [l2_mem_pkg::beat_w-1:0] rdata_q;
    logic [cnt_w-1:0]              countdown;
    logic [cnt_w-1:0]              first_count;
    logic [2:0]                    lat_seq;
    logic [1:0]                    extra;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign strobe = ram_req.rstrobe | ram_req.wstrobe;

    // Extra latency 0..3, scrambled so it does not just count up
    assign extra = lat_seq[1:0] ^ {lat_seq[2], 1'b0};

    // Two cycles go to latching the strobe and registering complete
    assign first_count = cnt_w'(MIN_LAT - 2) + cnt_w'(extra);

    assign done = busy && (countdown == '0);

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            complete_q <= 1'b0;
            countdown  <= '0;
            lat_seq    <= '0;
        end else begin
            complete_q <= 1'b0;
            if (!busy) begin
                if (strobe) begin
                    busy      <= 1'b1;
                    countdown <= first_count;
                    lat_seq   <= lat_seq + 1'b1;
                end
            end else if (done) begin
                // ready comes back in the same cycle as complete
                busy       <= 1'b0;
                complete_q <= 1'b1;
            end else begin
                countdown <= countdown - 1'b1;
            end
        end
    end

    // Operation latch; upper address bits alias
    always_ff @(posedge clk_cpu) begin
        if (!busy && strobe) begin
            op_write <= ram_req.wstrobe;
            word_q   <= ram_req.addr[l2_mem_pkg::word_off_w +: word_aw];
            wdata_q  <= ram_req.wdata;
        end
    end

    // Array access at the end of the countdown
    always_ff @(posedge clk_cpu) begin
        if (done) begin
            if (op_write) begin
                mem[word_q] <= wdata_q;
            end else begin
                rdata_q <= mem[word_q];
            end
        end
    end

    assign ram_rsp.rdata    = rdata_q;
    assign ram_rsp.complete = complete_q;
    assign ram_rsp.ready    = !busy;

    // Sequencer must wait for the previous beat before the next strobe
    a_strobe_when_ready: assert property (
        @(posedge clk_cpu) disable iff (!rst_n)
        strobe |-> ram_rsp.ready
    );

endmodule

`default_nettype wire

// File: design/line_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module line_sequencer (
    input  logic                               clk_cpu,
    input  logic                               rst_n,
    input  logic                               read_req,
    input  logic                               write_req,
    input  logic [l2_mem_pkg::tag_w-1:0]       tag,
    input  logic [l2_mem_pkg::tag_w-1:0]       write_tag,
    input  logic [l2_mem_pkg::index_w-1:0]     index,
    input  logic [l2_mem_pkg::line_w-1:0]      write_data,
    output logic [l2_mem_pkg::line_w-1:0]      read_data,
    output logic                               line_ready,
    output l2_mem_pkg::ram_req_t               ram_req,
    input  l2_mem_pkg::ram_rsp_t               ram_rsp
);

    typedef enum logic [2:0] {
        st_idle,
        st_issue_wr,
        st_wait_wr,
        st_issue_rd,
        st_wait_rd
    } state_t;

    state_t                                  state_q;
    logic [l2_mem_pkg::beat_cnt_w-1:0]       beat_cnt;
    logic                                    last_beat;
    logic                                    issue_wr;
    logic                                    issue_rd;
    logic                                    rstrobe_q;
    logic                                    wstrobe_q;
    logic [l2_mem_pkg::addr_w-1:0]           addr_q;
    logic [l2_mem_pkg::beat_w-1:0]           wdata_q;
    logic [l2_mem_pkg::addr_w-1:0]           wr_base;
    logic [l2_mem_pkg::addr_w-1:0]           rd_base;
    logic [l2_mem_pkg::addr_w-1:0]           beat_off;

    // Line base address from the low tag bits and the index
    assign wr_base = {write_tag[l2_mem_pkg::addr_tag_w-1:0], index,
                      {l2_mem_pkg::line_off_w{1'b0}}};
    assign rd_base = {tag[l2_mem_pkg::addr_tag_w-1:0], index,
                      {l2_mem_pkg::line_off_w{1'b0}}};

    // Beat number times eight bytes
    assign beat_off = {{(l2_mem_pkg::addr_w - l2_mem_pkg::beat_cnt_w
                         - l2_mem_pkg::word_off_w){1'b0}},
                       beat_cnt, {l2_mem_pkg::word_off_w{1'b0}}};

    assign last_beat = &beat_cnt;
    assign issue_wr  = (state_q == st_issue_wr) && ram_rsp.ready;
    assign issue_rd  = (state_q == st_issue_rd) && ram_rsp.ready;

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            rstrobe_q  <= 1'b0;
            wstrobe_q  <= 1'b0;
            line_ready <= 1'b0;
        end else begin
            rstrobe_q  <= 1'b0;
            wstrobe_q  <= 1'b0;
            line_ready <= 1'b0;
            case (state_q)
                st_idle: begin
                    // Requester drops its level while line_ready is high
                    if (!line_ready) begin
                        if (read_req) begin
                            state_q <= st_issue_rd;
                        end else if (write_req) begin
                            state_q <= st_issue_wr;
                        end
                    end
                end
                st_issue_wr: begin
                    if (ram_rsp.ready) begin
                        wstrobe_q <= 1'b1;
                        state_q   <= st_wait_wr;
                    end
                end
                st_wait_wr: begin
                    if (ram_rsp.complete) begin
                        line_ready <= last_beat;
                        state_q    <= last_beat ? st_idle : st_issue_wr;
                    end
                end
                st_issue_rd: begin
                    if (ram_rsp.ready) begin
                        rstrobe_q <= 1'b1;
                        state_q   <= st_wait_rd;
                    end
                end
                st_wait_rd: begin
                    if (ram_rsp.complete) begin
                        line_ready <= last_beat;
                        state_q    <= last_beat ? st_idle : st_issue_rd;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // Wraps back to zero after the eighth beat
    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (ram_rsp.complete) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Beat address and data, loaded with the strobe
    always_ff @(posedge clk_cpu) begin
        if (issue_wr) begin
            addr_q  <= wr_base + beat_off;
            wdata_q <= write_data[beat_cnt * l2_mem_pkg::beat_w +: l2_mem_pkg::beat_w];
        end else if (issue_rd) begin
            addr_q  <= rd_base + beat_off;
        end
    end

    // Each read beat lands in its own slot
    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if ((state_q == st_wait_rd) && ram_rsp.complete) begin
            read_data[beat_cnt * l2_mem_pkg::beat_w +: l2_mem_pkg::beat_w] <= ram_rsp.rdata;
        end
    end

    assign ram_req.addr    = addr_q;
    assign ram_req.wdata   = wdata_q;
    assign ram_req.rstrobe = rstrobe_q;
    assign ram_req.wstrobe = wstrobe_q;

    a_one_strobe: assert property (
        @(posedge clk_cpu) disable iff (!rst_n)
        !(ram_req.rstrobe && ram_req.wstrobe)
    );

endmodule

`default_nettype wire

// File: design/rst_stretch.sv
`timescale 1ns/10ps
`default_nettype none

module rst_stretch #(
    parameter int RST_CYCLES = 32
) (
    input  logic clk_cpu,
    input  logic rst_n,
    output logic rst_int_n
);

    // Ones shift in from the bottom once rst_n is released
    logic [RST_CYCLES-1:0] stretch_q;

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            stretch_q <= '0;
        end else begin
            stretch_q <= {stretch_q[RST_CYCLES-2:0], 1'b1};
        end
    end

    // Asserts at once, releases after the one reaches the top bit
    assign rst_int_n = stretch_q[RST_CYCLES-1];

endmodule

`default_nettype wire

// File: design/l2_mem_pkg.sv
`default_nettype none

package l2_mem_pkg;

    // Line and beat geometry
    localparam int line_w         = 512;
    localparam int beat_w         = 64;
    localparam int beats_per_line = line_w / beat_w;
    localparam int beat_cnt_w     = $clog2(beats_per_line);

    // Memory byte address
    localparam int addr_w     = 28;
    localparam int word_off_w = $clog2(beat_w / 8);
    localparam int line_off_w = $clog2(line_w / 8);

    // Cache address fields
    localparam int tag_w   = 18;
    localparam int index_w = 8;

    // Tag bits that still fit in the byte address
    localparam int addr_tag_w = addr_w - index_w - line_off_w;

    // Sequencer to memory, one beat per strobe
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [beat_w-1:0] wdata;
        logic              rstrobe;
        logic              wstrobe;
    } ram_req_t;

    // Memory to sequencer
    typedef struct packed {
        logic [beat_w-1:0] rdata;
        logic              complete;
        logic              ready;
    } ram_rsp_t;

endpackage

`default_nettype wire
